// File: Bender.yml
package:
  name: decode_top

sources:
  # packages first, then the design from the leaves up to the top level.
  - verilog/isa_pkg.sv
  - verilog/core_pkg.sv
  - verilog/inst_decoder.sv
  - verilog/id_stage.sv
  - verilog/id_reg.sv
  - verilog/issue_queue.sv
  - verilog/decode_top.sv

  - target: test
    files:
      - dv/decode_top_sva.sv
      - dv/decode_top_tb.sv

// File: decode_top.f
verilog/isa_pkg.sv
verilog/core_pkg.sv
verilog/inst_decoder.sv
verilog/id_stage.sv
verilog/id_reg.sv
verilog/issue_queue.sv
verilog/decode_top.sv
dv/decode_top_sva.sv
dv/decode_top_tb.sv

// File: dv/decode_top_sva.sv
`timescale 1ns/1ns

module decode_top_sva (
    input logic aclk,
    input logic arst_n,
    input logic flush,
    input logic in_ready,
    input logic iq_valid,
    input logic q_full,
    input logic q_pop
);
    int fail_count = 0;

    // without a pop or flush a full queue keeps its count, so no pair was written into it.
    a_no_write_when_full: assert property (@(posedge aclk) disable iff (!arst_n)
        q_full && !q_pop && !flush |=> q_full) else begin
        fail_count++;
        $error("a pair was written into a full issue queue");
    end

    a_flush_empties: assert property (@(posedge aclk) disable iff (!arst_n)
        flush |=> !iq_valid) else begin
        fail_count++;
        $error("iq_valid still high one cycle after flush");
    end

    a_ready_after_reset: assert property (@(posedge aclk) $rose(arst_n) |-> in_ready) else begin
        fail_count++;
        $error("in_ready low in the first cycle after reset");
    end

endmodule

bind decode_top decode_top_sva u_sva (
    .aclk     (aclk),
    .arst_n   (arst_n),
    .flush    (flush),
    .in_ready (in_ready),
    .iq_valid (iq_valid),
    .q_full   (u_issue_queue.full),
    .q_pop    (u_issue_queue.pop)
);

// File: dv/decode_top_tb.sv
`timescale 1ns/1ns

module decode_top_tb;
    import isa_pkg::*;
    import core_pkg::*;

    localparam int IQ_DEPTH   = 4;
    localparam int NUM_ROWS   = 11;
    localparam int VEC_W      = 8 * XLEN + 1 + 7 + 8 + 6 * REG_W + 4;
    localparam int MAX_CYCLES = (3 * NUM_ROWS + 1) * 20 + 100; // rows are offered about three times.

    typedef struct {
        logic [5:0]      op0, op1;                  // raw opcodes, so illegal values fit.
        logic [11:0]     imm0, imm1;
        excp_e           fetch_exc;
        uop_e            uop0, uop1;
        logic [XLEN-1:0] simm0, simm1;
        excp_e           exc;
        logic [3:0]      flags;                     // is_alu0, is_alu1, is_priv0, is_priv1.
    } row_t;

    // ##################################################
    // stimulus and expected decode
    // ##################################################
    row_t rows [NUM_ROWS] = '{
        '{6'h01, 6'h02, 12'h123, 12'h800, EXP_NONE, UOP_ALU_ADD, UOP_ALU_SUB,
          32'h0000_0123, 32'hffff_f800, EXP_NONE, 4'b1100},
        '{6'h03, 6'h04, 12'h7ff, 12'hfff, EXP_NONE, UOP_ALU_AND, UOP_ALU_OR,
          32'h0000_07ff, 32'hffff_ffff, EXP_NONE, 4'b1100},
        '{6'h05, 6'h06, 12'h801, 12'h010, EXP_NONE, UOP_ALU_ADD, UOP_LOAD,
          32'hffff_f801, 32'h0000_0010, EXP_NONE, 4'b1000},
        '{6'h07, 6'h08, 12'h444, 12'habc, EXP_NONE, UOP_STORE, UOP_BRANCH,
          32'h0000_0444, 32'hffff_fabc, EXP_NONE, 4'b0000},
        '{6'h00, 6'h0b, 12'h000, 12'h3c0, EXP_NONE, UOP_NOP, UOP_CSR,
          32'h0000_0000, 32'h0000_03c0, EXP_NONE, 4'b1001},
        '{6'h09, 6'h01, 12'h015, 12'h002, EXP_NONE, UOP_SYS, UOP_ALU_ADD,
          32'h0000_0015, 32'h0000_0002, EXP_SYS, 4'b0100},
        '{6'h0a, 6'h02, 12'h9a5, 12'h07c, EXP_NONE, UOP_SYS, UOP_ALU_SUB,
          32'hffff_f9a5, 32'h0000_007c, EXP_BRK, 4'b0100},
        '{6'h01, 6'h09, 12'h030, 12'hc00, EXP_NONE, UOP_ALU_ADD, UOP_SYS,
          32'h0000_0030, 32'hffff_fc00, EXP_NONE, 4'b1000},
        '{6'h09, 6'h3f, 12'h111, 12'h222, EXP_NONE, UOP_SYS, UOP_NOP,
          32'h0000_0111, 32'h0000_0222, EXP_INE, 4'b0000},
        '{6'h0b, 6'h20, 12'h0f0, 12'hf0f, EXP_NONE, UOP_CSR, UOP_NOP,
          32'h0000_00f0, 32'hffff_ff0f, EXP_INE, 4'b0010},
        '{6'h3f, 6'h0a, 12'h555, 12'haaa, EXP_ADEF, UOP_NOP, UOP_SYS,
          32'h0000_0555, 32'hffff_faaa, EXP_ADEF, 4'b0000}
    };

    logic             aclk, arst_n, flush, in_valid, in_ready, in_pc_taken, iq_pop, iq_valid;
    logic [XLEN-1:0]  in_inst0, in_inst1, in_pc0, in_pc1, in_pc_next, in_badv;
    excp_e            in_exception;
    logic [XLEN-1:0]  iq_inst0, iq_inst1, iq_pc0, iq_pc1, iq_pc_next, iq_badv, iq_imm0, iq_imm1;
    logic             iq_pc_taken, iq_is_alu0, iq_is_alu1, iq_is_priv0, iq_is_priv1;
    excp_e            iq_exception;
    uop_e             iq_uop0, iq_uop1;
    logic [REG_W-1:0] iq_rd0, iq_rd1, iq_rj0, iq_rj1, iq_rk0, iq_rk1;
    logic [VEC_W-1:0] got_vec;
    logic [VEC_W-1:0] exp_q [$];
    int               id_q [$];
    int               pop_pct = 0;
    int               cycles = 0;
    int               value_errs = 0;
    int               flow_errs = 0;
    int               sva_errs;

    decode_top #(.IQ_DEPTH(IQ_DEPTH)) u_decode_top (.*);

    assign got_vec = {iq_inst0, iq_inst1, iq_pc0, iq_pc1, iq_pc_next, iq_badv, iq_imm0, iq_imm1,
                      iq_pc_taken, iq_exception, iq_uop0, iq_uop1, iq_rd0, iq_rj0, iq_rk0,
                      iq_rd1, iq_rj1, iq_rk1, iq_is_alu0, iq_is_alu1, iq_is_priv0, iq_is_priv1};

    function automatic logic [XLEN-1:0] slot_inst(logic [5:0] op, logic [11:0] imm, int rbase);
        return {op, 4'b0000, imm, 5'(rbase + 7), 5'(rbase)}; // rj above rd, rk is imm[4:0].
    endfunction

    function automatic logic [XLEN-1:0] pc_of(int idx);
        return 32'h1c00_0000 + 32'(idx) * 16;
    endfunction

    function automatic logic [VEC_W-1:0] expect_vec(int idx);
        row_t            r;
        logic [XLEN-1:0] pc;
        r  = rows[idx];
        pc = pc_of(idx);
        return {slot_inst(r.op0, r.imm0, idx), slot_inst(r.op1, r.imm1, idx + 16),
                pc, pc + 32'd4, pc + 32'h100, ((r.fetch_exc == EXP_ADEF) ? pc : 32'h0),
                r.simm0, r.simm1, 1'(idx % 2), r.exc, r.uop0, r.uop1,
                5'(idx), 5'(idx + 7), r.imm0[4:0], 5'(idx + 16), 5'(idx + 23), r.imm1[4:0],
                r.flags};
    endfunction

    // entered a moment after a rising edge, and leaves the same way.
    task automatic offer_row(int idx);
        in_inst0     = slot_inst(rows[idx].op0, rows[idx].imm0, idx);
        in_inst1     = slot_inst(rows[idx].op1, rows[idx].imm1, idx + 16);
        in_pc0       = pc_of(idx);
        in_pc1       = pc_of(idx) + 32'd4;
        in_pc_next   = pc_of(idx) + 32'h100;
        in_pc_taken  = 1'(idx % 2);
        in_badv      = (rows[idx].fetch_exc == EXP_ADEF) ? pc_of(idx) : 32'h0;
        in_exception = rows[idx].fetch_exc;
        in_valid     = 1'b1;
        @(negedge aclk);
        while (!in_ready) begin
            @(negedge aclk);
        end
        exp_q.push_back(expect_vec(idx));           // the pair transfers at the coming edge.
        id_q.push_back(idx);
        @(posedge aclk);
        #1;
        in_valid = 1'b0;
    endtask

    task automatic drain();
        while (exp_q.size() != 0) begin
            @(negedge aclk);
        end
        repeat (3) @(negedge aclk);
        if (iq_valid) begin
            $display("Error at time %0t: a pair is left in the queue after all were popped",
                     $time);
            flow_errs++;
        end
        @(posedge aclk);
        #1;
    endtask

    // ##################################################
    // clock, pop pressure, monitor and watchdog
    // ##################################################
    initial begin
        aclk = 1'b0;
        forever #2 aclk = ~aclk;
    end

    initial begin
        int pct;
        void'($urandom(32'h985f4dcf));
        iq_pop = 1'b0;
        forever begin
            @(posedge aclk);
            pct = pop_pct;
            #1;
            iq_pop = ($urandom % 100) < pct;
        end
    end

    always @(negedge aclk) begin
        if (arst_n && !flush && iq_valid && iq_pop) begin
            if (exp_q.size() == 0) begin
                $display("Error at time %0t: a pair left the queue that was never sent", $time);
                flow_errs++;
            end else begin
                if (got_vec !== exp_q[0]) begin
                    $display("Error at time %0t: row %0d head %h expected %h",
                             $time, id_q[0], got_vec, exp_q[0]);
                    value_errs++;
                end
                void'(exp_q.pop_front());
                void'(id_q.pop_front());
            end
        end
    end

    initial begin
        while (cycles < MAX_CYCLES) begin
            @(posedge aclk);
            cycles++;
        end
        $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
        $display("Test failed");
        $finish;
    end

    initial begin
        arst_n       = 1'b0;
        flush        = 1'b0;
        in_valid     = 1'b0;
        in_inst0     = INST_NOP;
        in_inst1     = INST_NOP;
        in_pc0       = '0;
        in_pc1       = '0;
        in_pc_next   = '0;
        in_pc_taken  = 1'b0;
        in_badv      = '0;
        in_exception = EXP_NONE;
        repeat (8) @(posedge aclk);
        #1;
        arst_n = 1'b1;
        @(negedge aclk);
        if (!in_ready || iq_valid) begin
            $display("Error at time %0t: in_ready low or iq_valid high after reset", $time);
            flow_errs++;
        end
        @(posedge aclk);
        #1;
        pop_pct = 50;                               // whole table under random pops.
        for (int i = 0; i < NUM_ROWS; i++) begin
            offer_row(i);
        end
        drain();
        pop_pct = 100;                              // head appears two cycles after transfer.
        offer_row(0);
        @(negedge aclk);
        if (iq_valid) begin
            $display("Error at time %0t: pair reached the head one cycle after transfer", $time);
            flow_errs++;
        end
        @(negedge aclk);
        if (!iq_valid) begin
            $display("Error at time %0t: pair missing at the head two cycles after transfer",
                     $time);
            flow_errs++;
        end
        drain();
        pop_pct = 0;                                // back-pressure with the back end stalled.
        for (int i = 0; i <= IQ_DEPTH; i++) begin
            offer_row(i);
        end
        @(negedge aclk);
        if (in_ready) begin
            $display("Error at time %0t: in_ready stayed high with a full queue", $time);
            flow_errs++;
        end
        @(posedge aclk);
        #1;
        pop_pct = 50;
        for (int i = IQ_DEPTH + 1; i < NUM_ROWS; i++) begin
            offer_row(i);
        end
        drain();
        pop_pct = 0;                                // flush with pairs in flight.
        for (int i = 0; i < 3; i++) begin
            offer_row(i);
        end
        flush = 1'b1;
        exp_q.delete();
        id_q.delete();
        @(posedge aclk);
        #1;
        flush = 1'b0;
        if (iq_valid) begin
            $display("Error at time %0t: iq_valid high after flush", $time);
            flow_errs++;
        end
        pop_pct = 50;
        for (int i = 3; i < NUM_ROWS; i++) begin
            offer_row(i);
        end
        drain();
        sva_errs = u_decode_top.u_sva.fail_count;
        $display("Summary: value errors %0d, flow errors %0d, assertion failures %0d",
                 value_errs, flow_errs, sva_errs);
        if (value_errs + flow_errs + sva_errs == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: verilog/core_pkg.sv
package core_pkg;

    // ##################################################
    // datapath widths
    // ##################################################
    localparam int XLEN  = 32;                      // pc, instruction and immediate width.
    localparam int REG_W = 5;                       // width of an architectural register index.

    // ##################################################
    // pipeline defaults
    // ##################################################

    // the nop has an all zero opcode field and all zero operands.
    localparam logic [XLEN-1:0] INST_NOP = 32'h0000_0000;

    localparam int IQ_DEPTH_DEF = 4;                // instruction pairs held by the issue queue.

endpackage

// File: verilog/decode_top.sv
`timescale 1ns/1ns

module decode_top #(
    parameter int IQ_DEPTH = core_pkg::IQ_DEPTH_DEF
) (
    input  logic                       aclk,
    input  logic                       arst_n,
    input  logic                       flush,
    input  logic                       in_valid,
    output logic                       in_ready,
    input  logic [core_pkg::XLEN-1:0]  in_inst0, in_inst1,
    input  logic [core_pkg::XLEN-1:0]  in_pc0, in_pc1, in_pc_next,
    input  logic                       in_pc_taken,
    input  logic [core_pkg::XLEN-1:0]  in_badv,
    input  isa_pkg::excp_e             in_exception,
    input  logic                       iq_pop,
    output logic                       iq_valid,
    output logic [core_pkg::XLEN-1:0]  iq_inst0, iq_inst1,
    output logic [core_pkg::XLEN-1:0]  iq_pc0, iq_pc1, iq_pc_next,
    output logic                       iq_pc_taken,
    output logic [core_pkg::XLEN-1:0]  iq_badv,
    output isa_pkg::excp_e             iq_exception,
    output isa_pkg::uop_e              iq_uop0, iq_uop1,
    output logic [core_pkg::XLEN-1:0]  iq_imm0, iq_imm1,
    output logic [core_pkg::REG_W-1:0] iq_rd0, iq_rd1, iq_rj0, iq_rj1, iq_rk0, iq_rk1,
    output logic                       iq_is_alu0, iq_is_alu1,
    output logic                       iq_is_priv0, iq_is_priv1
);
    import isa_pkg::*;
    import core_pkg::*;

    // ##################################################
    // decode to pipeline register
    // ##################################################
    uop_e              uop0, uop1;
    logic [XLEN-1:0]   imm0, imm1;
    logic [REG_W-1:0]  rd0, rd1, rj0, rj1, rk0, rk1;
    logic              is_alu0, is_alu1, is_priv0, is_priv1;
    logic              is_syscall0, is_break0;
    logic              invalid_instruction;

    // ##################################################
    // pipeline register to issue queue
    // ##################################################
    logic              reg_valid, reg_allowin;
    logic [XLEN-1:0]   reg_inst0, reg_inst1, reg_pc0, reg_pc1, reg_pc_next, reg_badv;
    logic              reg_pc_taken;
    excp_e             reg_exception;
    uop_e              reg_uop0, reg_uop1;
    logic [XLEN-1:0]   reg_imm0, reg_imm1;
    logic [REG_W-1:0]  reg_rd0, reg_rd1, reg_rj0, reg_rj1, reg_rk0, reg_rk1;
    logic              reg_is_alu0, reg_is_alu1, reg_is_priv0, reg_is_priv1;

    // slot 1 traps are not taken, so its syscall and break flags stop here.
    id_stage u_id_stage (
        .is_syscall1 (),
        .is_break1   (),
        .*
    );

    // decode is combinational, so an offered pair is ready to go at once.
    id_reg u_id_reg (
        .id_readygo (in_valid),
        .id_allowin (in_ready),
        .*
    );

    issue_queue #(
        .IQ_DEPTH (IQ_DEPTH)
    ) u_issue_queue (
        .*
    );

endmodule

// File: verilog/id_reg.sv
`timescale 1ns/1ns

module id_reg (
    input  logic                       aclk,
    input  logic                       arst_n,
    input  logic                       flush,
    input  logic                       id_readygo,
    output logic                       id_allowin,
    input  logic                       reg_allowin,
    output logic                       reg_valid,
    input  logic [core_pkg::XLEN-1:0]  in_inst0, in_inst1,
    input  logic [core_pkg::XLEN-1:0]  in_pc0, in_pc1, in_pc_next,
    input  logic                       in_pc_taken,
    input  logic [core_pkg::XLEN-1:0]  in_badv,
    input  isa_pkg::excp_e             in_exception,
    input  isa_pkg::uop_e              uop0, uop1,
    input  logic [core_pkg::XLEN-1:0]  imm0, imm1,
    input  logic [core_pkg::REG_W-1:0] rd0, rd1, rj0, rj1, rk0, rk1,
    input  logic                       is_alu0, is_alu1,
    input  logic                       is_syscall0, is_break0,
    input  logic                       is_priv0, is_priv1,
    input  logic                       invalid_instruction,
    output logic [core_pkg::XLEN-1:0]  reg_inst0, reg_inst1,
    output logic [core_pkg::XLEN-1:0]  reg_pc0, reg_pc1, reg_pc_next,
    output logic                       reg_pc_taken,
    output logic [core_pkg::XLEN-1:0]  reg_badv,
    output isa_pkg::excp_e             reg_exception,
    output isa_pkg::uop_e              reg_uop0, reg_uop1,
    output logic [core_pkg::XLEN-1:0]  reg_imm0, reg_imm1,
    output logic [core_pkg::REG_W-1:0] reg_rd0, reg_rd1, reg_rj0, reg_rj1, reg_rk0, reg_rk1,
    output logic                       reg_is_alu0, reg_is_alu1,
    output logic                       reg_is_priv0, reg_is_priv1
);
    import isa_pkg::*;
    import core_pkg::*;

    logic  take;
    logic  bubble;
    excp_e excp_next;

    assign id_allowin = !reg_valid || reg_allowin;  // empty, or the queue takes our pair now.
    assign take       = id_readygo && id_allowin;
    assign bubble     = flush || (id_allowin && !id_readygo);

    // fetch faults win over decode faults, and only slot 0 may trap on syscall or break.
    always_comb begin
        if (in_exception != EXP_NONE) begin
            excp_next = in_exception;
        end else if (invalid_instruction) begin
            excp_next = EXP_INE;
        end else if (is_syscall0) begin
            excp_next = EXP_SYS;
        end else if (is_break0) begin
            excp_next = EXP_BRK;
        end else begin
            excp_next = EXP_NONE;
        end
    end

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            reg_valid <= 1'b0;
        end else if (flush) begin
            reg_valid <= 1'b0;
        end else if (id_allowin) begin
            reg_valid <= id_readygo;
        end
    end

    // ##################################################
    // payload, held whenever id_allowin is low
    // ##################################################
    always_ff @(posedge aclk) begin
        if (bubble) begin
            reg_inst0     <= INST_NOP;
            reg_inst1     <= INST_NOP;
            reg_exception <= EXP_NONE;
            reg_uop0      <= UOP_NOP;
            reg_uop1      <= UOP_NOP;
            reg_is_alu0   <= 1'b1;
            reg_is_alu1   <= 1'b1;
            reg_is_priv0  <= 1'b0;
            reg_is_priv1  <= 1'b0;
        end else if (take) begin
            reg_inst0     <= in_inst0;
            reg_inst1     <= in_inst1;
            reg_pc0       <= in_pc0;
            reg_pc1       <= in_pc1;
            reg_pc_next   <= in_pc_next;
            reg_pc_taken  <= in_pc_taken;
            reg_badv      <= in_badv;
            reg_exception <= excp_next;
            reg_uop0      <= uop0;
            reg_uop1      <= uop1;
            reg_imm0      <= imm0;
            reg_imm1      <= imm1;
            reg_rd0       <= rd0;
            reg_rd1       <= rd1;
            reg_rj0       <= rj0;
            reg_rj1       <= rj1;
            reg_rk0       <= rk0;
            reg_rk1       <= rk1;
            reg_is_alu0   <= is_alu0;
            reg_is_alu1   <= is_alu1;
            reg_is_priv0  <= is_priv0;
            reg_is_priv1  <= is_priv1;
        end
    end

endmodule

// File: verilog/id_stage.sv
`timescale 1ns/1ns

module id_stage (
    input  logic [core_pkg::XLEN-1:0]  in_inst0,
    input  logic [core_pkg::XLEN-1:0]  in_inst1,
    output isa_pkg::uop_e              uop0, uop1,
    output logic [core_pkg::XLEN-1:0]  imm0, imm1,
    output logic [core_pkg::REG_W-1:0] rd0, rd1,
    output logic [core_pkg::REG_W-1:0] rj0, rj1,
    output logic [core_pkg::REG_W-1:0] rk0, rk1,
    output logic                       is_alu0, is_alu1,
    output logic                       is_syscall0, is_syscall1,
    output logic                       is_break0, is_break1,
    output logic                       is_priv0, is_priv1,
    output logic                       invalid_instruction
);
    logic illegal0;
    logic illegal1;

    inst_decoder u_dec0 (
        .inst       (in_inst0),
        .uop        (uop0),
        .imm        (imm0),
        .rd         (rd0),
        .rj         (rj0),
        .rk         (rk0),
        .is_alu     (is_alu0),
        .is_syscall (is_syscall0),
        .is_break   (is_break0),
        .is_priv    (is_priv0),
        .illegal    (illegal0)
    );

    inst_decoder u_dec1 (
        .inst       (in_inst1),
        .uop        (uop1),
        .imm        (imm1),
        .rd         (rd1),
        .rj         (rj1),
        .rk         (rk1),
        .is_alu     (is_alu1),
        .is_syscall (is_syscall1),
        .is_break   (is_break1),
        .is_priv    (is_priv1),
        .illegal    (illegal1)
    );

    // the pair carries one exception code, so either slot faults the whole pair.
    assign invalid_instruction = illegal0 || illegal1;

endmodule

// File: verilog/inst_decoder.sv
`timescale 1ns/1ns

module inst_decoder (
    input  logic [core_pkg::XLEN-1:0]  inst,
    output isa_pkg::uop_e              uop,
    output logic [core_pkg::XLEN-1:0]  imm,
    output logic [core_pkg::REG_W-1:0] rd,
    output logic [core_pkg::REG_W-1:0] rj,
    output logic [core_pkg::REG_W-1:0] rk,
    output logic                       is_alu,
    output logic                       is_syscall,
    output logic                       is_break,
    output logic                       is_priv,
    output logic                       illegal
);
    import isa_pkg::*;
    import core_pkg::*;

    opcode_e opcode;

    assign opcode = opcode_e'(inst[OPC_MSB:OPC_LSB]);

    // fields are extracted for every opcode, the back end ignores the ones it does not need.
    assign imm = {{(XLEN - IMM_W){inst[IMM_MSB]}}, inst[IMM_MSB:IMM_LSB]};
    assign rd  = inst[RD_LSB +: REG_W];
    assign rj  = inst[RJ_LSB +: REG_W];
    assign rk  = inst[RK_LSB +: REG_W];

    always_comb begin
        uop        = UOP_NOP;
        is_alu     = 1'b0;
        is_syscall = 1'b0;
        is_break   = 1'b0;
        is_priv    = 1'b0;
        illegal    = 1'b0;
        case (opcode)
            OP_NOP: begin
                is_alu = 1'b1;                      // a nop occupies an alu slot like a bubble.
            end
            OP_ADD, OP_ADDI: begin
                uop    = UOP_ALU_ADD;
                is_alu = 1'b1;
            end
            OP_SUB: begin
                uop    = UOP_ALU_SUB;
                is_alu = 1'b1;
            end
            OP_AND: begin
                uop    = UOP_ALU_AND;
                is_alu = 1'b1;
            end
            OP_OR: begin
                uop    = UOP_ALU_OR;
                is_alu = 1'b1;
            end
            OP_LD: begin
                uop = UOP_LOAD;
            end
            OP_ST: begin
                uop = UOP_STORE;
            end
            OP_BEQ: begin
                uop = UOP_BRANCH;
            end
            OP_SYSCALL: begin
                uop        = UOP_SYS;
                is_syscall = 1'b1;
            end
            OP_BREAK: begin
                uop      = UOP_SYS;
                is_break = 1'b1;
            end
            OP_CSRRD: begin
                uop     = UOP_CSR;
                is_priv = 1'b1;
            end
            default: begin
                illegal = 1'b1;                     // unknown opcode travels on as a nop.
            end
        endcase
    end

endmodule

// File: verilog/isa_pkg.sv
package isa_pkg;

    // ##################################################
    // instruction field positions
    // ##################################################
    localparam int OPC_MSB = 31;
    localparam int OPC_LSB = 26;
    localparam int IMM_MSB = 21;
    localparam int IMM_LSB = 10;
    localparam int IMM_W   = IMM_MSB - IMM_LSB + 1;
    localparam int RK_LSB  = 10;                    // rk overlaps the low immediate bits.
    localparam int RJ_LSB  = 5;
    localparam int RD_LSB  = 0;

    // ##################################################
    // opcodes, micro-ops and exception codes
    // ##################################################
    typedef enum logic [5:0] {
        OP_NOP     = 6'h00,
        OP_ADD     = 6'h01,
        OP_SUB     = 6'h02,
        OP_AND     = 6'h03,
        OP_OR      = 6'h04,
        OP_ADDI    = 6'h05,
        OP_LD      = 6'h06,
        OP_ST      = 6'h07,
        OP_BEQ     = 6'h08,
        OP_SYSCALL = 6'h09,
        OP_BREAK   = 6'h0a,
        OP_CSRRD   = 6'h0b                          // the only privileged opcode.
    } opcode_e;

    typedef enum logic [3:0] {
        UOP_NOP     = 4'h0,
        UOP_ALU_ADD = 4'h1,
        UOP_ALU_SUB = 4'h2,
        UOP_ALU_AND = 4'h3,
        UOP_ALU_OR  = 4'h4,
        UOP_LOAD    = 4'h5,
        UOP_STORE   = 4'h6,
        UOP_BRANCH  = 4'h7,
        UOP_SYS     = 4'h8,
        UOP_CSR     = 4'h9
    } uop_e;

    typedef enum logic [6:0] {
        EXP_NONE = 7'h00,
        EXP_ADEF = 7'h08,                           // raised by fetch, only passed on here.
        EXP_SYS  = 7'h0b,
        EXP_BRK  = 7'h0c,
        EXP_INE  = 7'h0d
    } excp_e;

endpackage

// File: verilog/issue_queue.sv
`timescale 1ns/1ns

module issue_queue #(
    parameter int IQ_DEPTH = core_pkg::IQ_DEPTH_DEF
) (
    input  logic                       aclk,
    input  logic                       arst_n,
    input  logic                       flush,
    input  logic                       reg_valid,
    output logic                       reg_allowin,
    input  logic [core_pkg::XLEN-1:0]  reg_inst0, reg_inst1,
    input  logic [core_pkg::XLEN-1:0]  reg_pc0, reg_pc1, reg_pc_next,
    input  logic                       reg_pc_taken,
    input  logic [core_pkg::XLEN-1:0]  reg_badv,
    input  isa_pkg::excp_e             reg_exception,
    input  isa_pkg::uop_e              reg_uop0, reg_uop1,
    input  logic [core_pkg::XLEN-1:0]  reg_imm0, reg_imm1,
    input  logic [core_pkg::REG_W-1:0] reg_rd0, reg_rd1, reg_rj0, reg_rj1, reg_rk0, reg_rk1,
    input  logic                       reg_is_alu0, reg_is_alu1,
    input  logic                       reg_is_priv0, reg_is_priv1,
    input  logic                       iq_pop,
    output logic                       iq_valid,
    output logic [core_pkg::XLEN-1:0]  iq_inst0, iq_inst1,
    output logic [core_pkg::XLEN-1:0]  iq_pc0, iq_pc1, iq_pc_next,
    output logic                       iq_pc_taken,
    output logic [core_pkg::XLEN-1:0]  iq_badv,
    output isa_pkg::excp_e             iq_exception,
    output isa_pkg::uop_e              iq_uop0, iq_uop1,
    output logic [core_pkg::XLEN-1:0]  iq_imm0, iq_imm1,
    output logic [core_pkg::REG_W-1:0] iq_rd0, iq_rd1, iq_rj0, iq_rj1, iq_rk0, iq_rk1,
    output logic                       iq_is_alu0, iq_is_alu1,
    output logic                       iq_is_priv0, iq_is_priv1
);
    import isa_pkg::*;
    import core_pkg::*;

    localparam int PTR_W  = $clog2(IQ_DEPTH);
    localparam int CNT_W  = $clog2(IQ_DEPTH + 1);
    localparam int DATA_W = 8 * XLEN + 6 * REG_W + 5; // plain bit fields of one pair.

    logic [DATA_W-1:0] data_mem [IQ_DEPTH];
    uop_e              uop0_mem [IQ_DEPTH];
    uop_e              uop1_mem [IQ_DEPTH];
    excp_e             excp_mem [IQ_DEPTH];
    logic [PTR_W-1:0]  rd_ptr;
    logic [PTR_W-1:0]  wr_ptr;
    logic [CNT_W-1:0]  count;
    logic              full;
    logic              push;
    logic              pop;

    assign iq_valid    = (count != '0);
    assign full        = (count == CNT_W'(IQ_DEPTH));
    assign pop         = iq_pop && iq_valid;    // a pop on an empty queue is dropped.
    assign reg_allowin = !full || pop;          // a full queue still frees the head slot.
    assign push        = reg_valid && reg_allowin;

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else if (flush) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;        // power of two depth wraps by itself.
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (push) begin
            data_mem[wr_ptr] <= {reg_inst0, reg_inst1, reg_pc0, reg_pc1, reg_pc_next, reg_badv,
                                 reg_imm0, reg_imm1, reg_rd0, reg_rd1, reg_rj0, reg_rj1,
                                 reg_rk0, reg_rk1, reg_pc_taken, reg_is_alu0, reg_is_alu1,
                                 reg_is_priv0, reg_is_priv1};
            uop0_mem[wr_ptr] <= reg_uop0;
            uop1_mem[wr_ptr] <= reg_uop1;
            excp_mem[wr_ptr] <= reg_exception;
        end
    end

    // ##################################################
    // head of queue
    // ##################################################
    assign {iq_inst0, iq_inst1, iq_pc0, iq_pc1, iq_pc_next, iq_badv,
            iq_imm0, iq_imm1, iq_rd0, iq_rd1, iq_rj0, iq_rj1,
            iq_rk0, iq_rk1, iq_pc_taken, iq_is_alu0, iq_is_alu1,
            iq_is_priv0, iq_is_priv1} = data_mem[rd_ptr];
    assign iq_uop0      = uop0_mem[rd_ptr];
    assign iq_uop1      = uop1_mem[rd_ptr];
    assign iq_exception = excp_mem[rd_ptr];

endmodule
